//--- verilog/snes_bus_pkg.sv
`default_nettype none

package snes_bus_pkg;

  // strobe sampling shift registers
  localparam int SYNC_DEPTH = 8;

  // tap holding the synchronized level, two samples after the pin
  localparam int SYNC_TAP = 1;

  // edge patterns are matched over taps SYNC_TAP .. SYNC_TAP+DECODE_W-1
  // newest sample is the rightmost bit
  localparam int DECODE_W = 6;
  localparam logic [DECODE_W-1:0] CYCLE_START_PAT = 6'b000001; // cpu clock rising
  localparam logic [DECODE_W-1:0] PULSE_END_PAT = 6'b000011;   // idle pulse after 4+ lows

  // console liveness
  typedef logic [17:0] dead_cnt_t;
  localparam dead_cnt_t DEAD_TIMEOUT_DEFAULT = 18'd96000; // about 1 ms

endpackage

`default_nettype wire

//--- verilog/rom_bus_pkg.sv
`default_nettype none

package rom_bus_pkg;

  localparam int ROM_ADDR_W = 24; // byte address
  localparam int ROM_DATA_W = 16;
  localparam int BYTE_W = 8;

  // value loaded into the access delay counter
  localparam int unsigned ROM_CYCLE_LEN_DEFAULT = 7;

  ////////////////////////////////////////////////////////////////////////////
  // arbiter states, one-hot
  // each end state sits one bit above its addr state
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [10:0] {
    ST_IDLE        = 11'b00000000001,
    ST_MCU_RD_ADDR = 11'b00000000010,
    ST_MCU_RD_END  = 11'b00000000100,
    ST_MCU_WR_ADDR = 11'b00000001000,
    ST_MCU_WR_END  = 11'b00000010000,
    ST_CTX_WR_ADDR = 11'b00000100000,
    ST_CTX_WR_END  = 11'b00001000000,
    ST_DMA_RD_ADDR = 11'b00010000000,
    ST_DMA_RD_END  = 11'b00100000000,
    ST_DMA_WR_ADDR = 11'b01000000000,
    ST_DMA_WR_END  = 11'b10000000000
  } rom_state_t;

  // requester payloads
  typedef struct packed {
    logic [ROM_ADDR_W-1:0] addr;
    logic [ROM_DATA_W-1:0] data;
    logic                  word;
  } ctx_req_t;

  typedef struct packed {
    logic [ROM_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]     data;
    logic                  rd;
  } mcu_req_t;

  typedef struct packed {
    logic [ROM_ADDR_W-1:0] addr;
    logic [ROM_DATA_W-1:0] data;
    logic                  word;
    logic                  rd;
  } dma_req_t;

endpackage

`default_nettype wire

//--- verilog/rom_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one requester's link to the arbiter and the ROM datapath
interface rom_req_if #(
  parameter type PAYLOAD_T = logic
);

  logic     pending_rd;
  logic     pending_wr;
  PAYLOAD_T payload;
  logic     done; // one cycle, in the matching end state

  modport port (
    output pending_rd,
    output pending_wr,
    output payload,
    input  done
  );

  modport arb (
    input  pending_rd,
    input  pending_wr,
    output done
  );

  modport data (
    input payload
  );

endinterface

`default_nettype wire

//--- verilog/snes_bus_sync.sv
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sync
  import snes_bus_pkg::*;
#(
  parameter dead_cnt_t DEAD_TIMEOUT = DEAD_TIMEOUT_DEFAULT
) (
  input  logic CLK2,
  input  logic SNES_reset_strobe,
  input  logic snes_read_in,
  input  logic snes_write_in,
  input  logic snes_cpu_clk_in,
  input  logic rom_hit,
  output logic free_slot,
  output logic snes_dead,
  output logic snes_clk_high
);

  logic [SYNC_DEPTH-1:0] read_sr;
  logic [SYNC_DEPTH-1:0] write_sr;
  logic [SYNC_DEPTH-1:0] cpu_clk_sr;
  logic [SYNC_DEPTH-1:0] pulse_sr;
  logic                  bus_idle;
  logic                  cycle_start;
  logic                  pulse_end;
  logic                  free_strobe;
  dead_cnt_t             dead_cnt;

  // no read, no write, cpu clock low
  assign bus_idle = read_sr[SYNC_TAP] & write_sr[SYNC_TAP] & ~cpu_clk_sr[SYNC_TAP];

  assign cycle_start = (cpu_clk_sr[SYNC_TAP +: DECODE_W] == CYCLE_START_PAT);
  assign pulse_end = (pulse_sr[SYNC_TAP +: DECODE_W] == PULSE_END_PAT);
  assign snes_clk_high = cpu_clk_sr[SYNC_TAP];

  assign free_slot = pulse_end | free_strobe;

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      read_sr <= '1;
      write_sr <= '1;
      cpu_clk_sr <= '0;
      pulse_sr <= '1;
      free_strobe <= 1'b0;
    end else begin
      read_sr <= {read_sr[SYNC_DEPTH-2:0], snes_read_in};
      write_sr <= {write_sr[SYNC_DEPTH-2:0], snes_write_in};
      cpu_clk_sr <= {cpu_clk_sr[SYNC_DEPTH-2:0], snes_cpu_clk_in};
      pulse_sr <= {pulse_sr[SYNC_DEPTH-2:0], bus_idle};
      free_strobe <= cycle_start & ~rom_hit; // cycle not aimed at ROM
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // liveness
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      dead_cnt <= '0;
      snes_dead <= 1'b1; // presumed dead until a clock is seen
    end else if (snes_clk_high) begin
      dead_cnt <= '0;
      snes_dead <= 1'b0;
    end else begin
      if (dead_cnt != '1) dead_cnt <= dead_cnt + 1'b1; // saturate
      if (dead_cnt > DEAD_TIMEOUT) snes_dead <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rom_request_port.sv
`timescale 1ns/1ps
`default_nettype none

module rom_request_port #(
  parameter type PAYLOAD_T = logic
) (
  input  logic     CLK2,
  input  logic     SNES_reset_strobe,
  input  logic     rrq,
  input  logic     wrq,
  input  PAYLOAD_T payload_in,
  output logic     rdy,
  rom_req_if.port  req
);

  // pending flags and ready level
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      req.pending_rd <= 1'b0;
      req.pending_wr <= 1'b0;
      rdy <= 1'b1;
    end else if (rrq) begin
      req.pending_rd <= 1'b1; // read wins over a same-cycle write
      rdy <= 1'b0;
    end else if (wrq) begin
      req.pending_wr <= 1'b1;
      rdy <= 1'b0;
    end else if (req.done) begin
      req.pending_rd <= 1'b0;
      req.pending_wr <= 1'b0;
      rdy <= 1'b1;
    end
  end

  // address and data held for the whole access
  always_ff @(posedge CLK2) begin
    if (rrq || wrq) begin
      req.payload <= payload_in;
    end
  end

endmodule

`default_nettype wire

//--- verilog/rom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter
  import rom_bus_pkg::*;
#(
  parameter int unsigned ROM_CYCLE_LEN = ROM_CYCLE_LEN_DEFAULT
) (
  input  logic       CLK2,
  input  logic       SNES_reset_strobe,
  input  logic       free_slot,
  input  logic       snes_dead,
  input  logic       snes_clk_high,
  rom_req_if.arb     ctx,
  rom_req_if.arb     mcu,
  rom_req_if.arb     dma,
  output rom_state_t state
);

  localparam int DELAY_W = $clog2(ROM_CYCLE_LEN + 2);

  logic [DELAY_W-1:0] delay_cnt;

  assign ctx.done = (state == ST_CTX_WR_END);
  assign mcu.done = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);
  assign dma.done = (state == ST_DMA_RD_END) || (state == ST_DMA_WR_END);

  //////////////////////////////////////////////////////////////////////////
  // access FSM
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      state <= ST_IDLE;
      delay_cnt <= '0;
    end else if (snes_dead && snes_clk_high) begin
      state <= ST_IDLE; // console woke up, drop the access and retry later
    end else begin
      unique case (state)
        ST_IDLE: begin
          if (free_slot || snes_dead) begin
            delay_cnt <= DELAY_W'(ROM_CYCLE_LEN);
            // fixed priority
            if (ctx.pending_wr) state <= ST_CTX_WR_ADDR;
            else if (mcu.pending_rd) state <= ST_MCU_RD_ADDR;
            else if (mcu.pending_wr) state <= ST_MCU_WR_ADDR;
            else if (dma.pending_rd) state <= ST_DMA_RD_ADDR;
            else if (dma.pending_wr) state <= ST_DMA_WR_ADDR;
          end
        end
        ST_MCU_RD_ADDR,
        ST_MCU_WR_ADDR,
        ST_CTX_WR_ADDR,
        ST_DMA_RD_ADDR,
        ST_DMA_WR_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) begin
            state <= rom_state_t'(state << 1); // matching end state
          end
        end
        ST_MCU_RD_END,
        ST_MCU_WR_END,
        ST_CTX_WR_END,
        ST_DMA_RD_END,
        ST_DMA_WR_END: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/rom_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module rom_datapath
  import rom_bus_pkg::*;
(
  input  logic                  CLK2,
  input  rom_state_t            state,
  input  logic [ROM_DATA_W-1:0] rom_data_in,
  input  logic [ROM_ADDR_W-1:0] mapped_addr,
  rom_req_if.data               ctx,
  rom_req_if.data               mcu,
  rom_req_if.data               dma,
  output logic [ROM_ADDR_W-2:0] rom_addr,
  output logic [ROM_DATA_W-1:0] rom_data_out,
  output logic                  rom_data_oe,
  output logic                  rom_we,
  output logic                  rom_bhe,
  output logic                  rom_ble,
  output logic [BYTE_W-1:0]     mcu_din,
  output logic [ROM_DATA_W-1:0] dma_din
);

  logic                  ctx_wr;
  logic                  mcu_wr;
  logic                  dma_wr;
  logic                  mcu_hit;
  logic                  dma_hit;
  logic                  word;
  logic                  addr0;
  logic [ROM_ADDR_W-1:0] sel_addr;
  logic [BYTE_W-1:0]     lo_lane;
  logic [BYTE_W-1:0]     hi_lane;

  assign ctx_wr = (state == ST_CTX_WR_ADDR);
  assign mcu_wr = (state == ST_MCU_WR_ADDR);
  assign dma_wr = (state == ST_DMA_WR_ADDR);
  assign dma_hit = dma_wr || (state == ST_DMA_RD_ADDR);
  assign mcu_hit = |(state & (ST_MCU_RD_ADDR | ST_MCU_RD_END | ST_MCU_WR_ADDR | ST_MCU_WR_END));

  // granted address, SNES side when nobody holds the bus
  always_comb begin
    if (ctx_wr) sel_addr = ctx.payload.addr;
    else if (dma_hit) sel_addr = dma.payload.addr;
    else if (mcu_hit) sel_addr = mcu.payload.addr;
    else sel_addr = mapped_addr;
  end

  assign rom_addr = sel_addr[ROM_ADDR_W-1:1];
  assign addr0 = sel_addr[0];

  assign word = (ctx_wr & ctx.payload.word) | (dma_hit & dma.payload.word);

  //////////////////////////////////////////////////////////////////////////
  // write lanes, word data goes out high byte first on the low lane
  //////////////////////////////////////////////////////////////////////////
  assign lo_lane = ctx_wr ? ctx.payload.data[ROM_DATA_W-1:BYTE_W]
                 : dma_wr ? dma.payload.data[ROM_DATA_W-1:BYTE_W]
                 : mcu.payload.data;
  assign hi_lane = ctx_wr ? ctx.payload.data[BYTE_W-1:0]
                 : dma_wr ? dma.payload.data[BYTE_W-1:0]
                 : mcu.payload.data;
  assign rom_data_out = {hi_lane, lo_lane};

  assign rom_data_oe = ctx_wr | dma_wr | mcu_wr;
  assign rom_we = ~rom_data_oe; // active low
  assign rom_bhe = addr0;
  assign rom_ble = ~(addr0 | word);

  // read capture, last addr cycle wins
  always_ff @(posedge CLK2) begin
    if (state == ST_MCU_RD_ADDR) begin
      mcu_din <= addr0 ? rom_data_in[BYTE_W-1:0] : rom_data_in[ROM_DATA_W-1:BYTE_W];
    end
    if (state == ST_DMA_RD_ADDR) begin
      dma_din <= addr0 ? rom_data_in
                       : {rom_data_in[BYTE_W-1:0], rom_data_in[ROM_DATA_W-1:BYTE_W]};
    end
  end

endmodule

`default_nettype wire

//--- verilog/snes_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module snes_mem_ctrl
  import snes_bus_pkg::*;
  import rom_bus_pkg::*;
#(
  parameter dead_cnt_t   DEAD_TIMEOUT  = DEAD_TIMEOUT_DEFAULT,
  parameter int unsigned ROM_CYCLE_LEN = ROM_CYCLE_LEN_DEFAULT
) (
  input  logic                  CLK2,
  input  logic                  SNES_reset_strobe,
  // SNES bus and mapper
  input  logic                  snes_read_in,
  input  logic                  snes_write_in,
  input  logic                  snes_cpu_clk_in,
  input  logic                  rom_hit,
  input  logic [ROM_ADDR_W-1:0] mapped_addr,
  // MCU
  input  logic                  mcu_rrq,
  input  logic                  mcu_wrq,
  input  logic [ROM_ADDR_W-1:0] mcu_addr,
  input  logic [BYTE_W-1:0]     mcu_dout,
  output logic                  mcu_rdy,
  output logic [BYTE_W-1:0]     mcu_din,
  // context save
  input  logic                  ctx_wrq,
  input  logic [ROM_ADDR_W-1:0] ctx_addr,
  input  logic [ROM_DATA_W-1:0] ctx_dout,
  input  logic                  ctx_word,
  output logic                  ctx_rdy,
  // DMA
  input  logic                  dma_rrq,
  input  logic                  dma_wrq,
  input  logic [ROM_ADDR_W-1:0] dma_addr,
  input  logic [ROM_DATA_W-1:0] dma_dout,
  input  logic                  dma_word,
  output logic                  dma_rdy,
  output logic [ROM_DATA_W-1:0] dma_din,
  // ROM bus
  output logic [ROM_ADDR_W-2:0] rom_addr,
  output logic [ROM_DATA_W-1:0] rom_data_out,
  input  logic [ROM_DATA_W-1:0] rom_data_in,
  output logic                  rom_data_oe,
  output logic                  rom_we,
  output logic                  rom_bhe,
  output logic                  rom_ble,
  output logic                  snes_dead
);

  logic       free_slot;
  logic       snes_clk_high;
  rom_state_t state;
  ctx_req_t   ctx_payload;
  mcu_req_t   mcu_payload;
  dma_req_t   dma_payload;

  rom_req_if #(.PAYLOAD_T(ctx_req_t)) ctx_if ();
  rom_req_if #(.PAYLOAD_T(mcu_req_t)) mcu_if ();
  rom_req_if #(.PAYLOAD_T(dma_req_t)) dma_if ();

  assign ctx_payload = '{addr: ctx_addr, data: ctx_dout, word: ctx_word};
  assign mcu_payload = '{addr: mcu_addr, data: mcu_dout, rd: mcu_rrq};
  assign dma_payload = '{addr: dma_addr, data: dma_dout, word: dma_word, rd: dma_rrq};

  snes_bus_sync #(
    .DEAD_TIMEOUT(DEAD_TIMEOUT)
  ) u_bus_sync (
    .CLK2             (CLK2),
    .SNES_reset_strobe(SNES_reset_strobe),
    .snes_read_in     (snes_read_in),
    .snes_write_in    (snes_write_in),
    .snes_cpu_clk_in  (snes_cpu_clk_in),
    .rom_hit          (rom_hit),
    .free_slot        (free_slot),
    .snes_dead        (snes_dead),
    .snes_clk_high    (snes_clk_high)
  );

  //////////////////////////////////////////////////////////////////////////
  // requesters
  //////////////////////////////////////////////////////////////////////////
  rom_request_port #(.PAYLOAD_T(ctx_req_t)) u_ctx_port (
    .CLK2             (CLK2),
    .SNES_reset_strobe(SNES_reset_strobe),
    .rrq              (1'b0), // write only
    .wrq              (ctx_wrq),
    .payload_in       (ctx_payload),
    .rdy              (ctx_rdy),
    .req              (ctx_if.port)
  );

  rom_request_port #(.PAYLOAD_T(mcu_req_t)) u_mcu_port (
    .CLK2             (CLK2),
    .SNES_reset_strobe(SNES_reset_strobe),
    .rrq              (mcu_rrq),
    .wrq              (mcu_wrq),
    .payload_in       (mcu_payload),
    .rdy              (mcu_rdy),
    .req              (mcu_if.port)
  );

  rom_request_port #(.PAYLOAD_T(dma_req_t)) u_dma_port (
    .CLK2             (CLK2),
    .SNES_reset_strobe(SNES_reset_strobe),
    .rrq              (dma_rrq),
    .wrq              (dma_wrq),
    .payload_in       (dma_payload),
    .rdy              (dma_rdy),
    .req              (dma_if.port)
  );

  rom_arbiter #(
    .ROM_CYCLE_LEN(ROM_CYCLE_LEN)
  ) u_arbiter (
    .CLK2             (CLK2),
    .SNES_reset_strobe(SNES_reset_strobe),
    .free_slot        (free_slot),
    .snes_dead        (snes_dead),
    .snes_clk_high    (snes_clk_high),
    .ctx              (ctx_if.arb),
    .mcu              (mcu_if.arb),
    .dma              (dma_if.arb),
    .state            (state)
  );

  rom_datapath u_datapath (
    .CLK2        (CLK2),
    .state       (state),
    .rom_data_in (rom_data_in),
    .mapped_addr (mapped_addr),
    .ctx         (ctx_if.data),
    .mcu         (mcu_if.data),
    .dma         (dma_if.data),
    .rom_addr    (rom_addr),
    .rom_data_out(rom_data_out),
    .rom_data_oe (rom_data_oe),
    .rom_we      (rom_we),
    .rom_bhe     (rom_bhe),
    .rom_ble     (rom_ble),
    .mcu_din     (mcu_din),
    .dma_din     (dma_din)
  );

endmodule

`default_nettype wire

//--- testbench/snes_mem_ctrl_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module snes_mem_ctrl_asserts
  import rom_bus_pkg::*;
(
  input logic       CLK2,
  input logic       SNES_reset_strobe,
  input rom_state_t state,
  input logic       ctx_done,
  input logic       mcu_done,
  input logic       dma_done
);

  localparam logic [10:0] END_MASK = ST_MCU_RD_END | ST_MCU_WR_END | ST_CTX_WR_END
                                   | ST_DMA_RD_END | ST_DMA_WR_END;

  int unsigned assert_fails = 0; // read by the testbench at the end
  logic        in_end;

  assign in_end = |(state & END_MASK);

  state_one_hot: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    $onehot(state))
    else begin
      $error("arbiter state %b is not one-hot", state);
      assert_fails++;
    end

  // end states last a single cycle
  end_then_idle: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    in_end |=> (state == ST_IDLE))
    else begin
      $error("end state not followed by idle");
      assert_fails++;
    end

  single_done: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    $onehot0({ctx_done, mcu_done, dma_done}))
    else begin
      $error("more than one done pulse at once");
      assert_fails++;
    end

endmodule

bind rom_arbiter snes_mem_ctrl_asserts u_asserts (
  .CLK2             (CLK2),
  .SNES_reset_strobe(SNES_reset_strobe),
  .state            (state),
  .ctx_done         (ctx.done),
  .mcu_done         (mcu.done),
  .dma_done         (dma.done)
);

`default_nettype wire

//--- testbench/tb_snes_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snes_mem_ctrl
  import rom_bus_pkg::*;
();

  localparam int DEAD_TIMEOUT = 40;
  localparam int CYCLE_LEN = 7;
  localparam int CLK_NS = 4;
  localparam int N_MCU = 16;
  localparam int N_DMA = 8;
  localparam int N_CTX = 8;
  localparam int N_OPS = 2 * N_MCU + 2 * N_DMA + 3 * N_CTX + 4;
  localparam int WAIT_LIMIT = 200; // cycles per access
  localparam int DEAD_PHASE = 12 * DEAD_TIMEOUT + 50;
  localparam int WATCHDOG_CYCLES = N_OPS * 40 + DEAD_PHASE;

  logic                  CLK2 = 1'b0;
  logic                  SNES_reset_strobe;
  logic                  snes_read_in;
  logic                  snes_write_in;
  logic                  snes_cpu_clk_in = 1'b0;
  logic                  rom_hit;
  logic [ROM_ADDR_W-1:0] mapped_addr;
  logic                  mcu_rrq;
  logic                  mcu_wrq;
  logic [ROM_ADDR_W-1:0] mcu_addr;
  logic [BYTE_W-1:0]     mcu_dout;
  logic                  mcu_rdy;
  logic [BYTE_W-1:0]     mcu_din;
  logic                  ctx_wrq;
  logic [ROM_ADDR_W-1:0] ctx_addr;
  logic [ROM_DATA_W-1:0] ctx_dout;
  logic                  ctx_word;
  logic                  ctx_rdy;
  logic                  dma_rrq;
  logic                  dma_wrq;
  logic [ROM_ADDR_W-1:0] dma_addr;
  logic [ROM_DATA_W-1:0] dma_dout;
  logic                  dma_word;
  logic                  dma_rdy;
  logic [ROM_DATA_W-1:0] dma_din;
  logic [ROM_ADDR_W-2:0] rom_addr;
  logic [ROM_DATA_W-1:0] rom_data_out;
  logic [ROM_DATA_W-1:0] rom_data_in;
  logic                  rom_data_oe;
  logic                  rom_we;
  logic                  rom_bhe;
  logic                  rom_ble;
  logic                  snes_dead;

  logic [15:0] rom_mem [0:127]; // behavioral ROM/PSRAM over a 256-byte window
  logic [7:0]  ref_mem [0:255]; // expected byte contents
  logic [7:0]  wr_addr [0:N_MCU-1];
  logic        cpu_clk_run = 1'b0;
  logic [3:0]  cpu_div = 4'd0;
  int          n_errors = 0;
  int          n_checks = 0;

  always #(CLK_NS / 2) CLK2 = ~CLK2;

  snes_mem_ctrl #(
    .DEAD_TIMEOUT (DEAD_TIMEOUT),
    .ROM_CYCLE_LEN(CYCLE_LEN)
  ) u_dut (
    .CLK2(CLK2), .SNES_reset_strobe(SNES_reset_strobe),
    .snes_read_in(snes_read_in), .snes_write_in(snes_write_in),
    .snes_cpu_clk_in(snes_cpu_clk_in), .rom_hit(rom_hit), .mapped_addr(mapped_addr),
    .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_addr(mcu_addr), .mcu_dout(mcu_dout),
    .mcu_rdy(mcu_rdy), .mcu_din(mcu_din),
    .ctx_wrq(ctx_wrq), .ctx_addr(ctx_addr), .ctx_dout(ctx_dout), .ctx_word(ctx_word),
    .ctx_rdy(ctx_rdy),
    .dma_rrq(dma_rrq), .dma_wrq(dma_wrq), .dma_addr(dma_addr), .dma_dout(dma_dout),
    .dma_word(dma_word), .dma_rdy(dma_rdy), .dma_din(dma_din),
    .rom_addr(rom_addr), .rom_data_out(rom_data_out), .rom_data_in(rom_data_in),
    .rom_data_oe(rom_data_oe), .rom_we(rom_we), .rom_bhe(rom_bhe), .rom_ble(rom_ble),
    .snes_dead(snes_dead)
  );

  ////////////////////////////////////////////////////////////////////////////
  // external memory and SNES cpu clock
  ////////////////////////////////////////////////////////////////////////////
  assign rom_data_in = rom_mem[rom_addr[6:0]];

  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (!rom_bhe) rom_mem[rom_addr[6:0]][15:8] <= rom_data_out[15:8];
      if (!rom_ble) rom_mem[rom_addr[6:0]][7:0] <= rom_data_out[7:0];
    end
  end

  // 6 low, 6 high while running, held low otherwise
  always @(posedge CLK2) begin
    if (!cpu_clk_run) begin
      cpu_div <= 4'd0;
      snes_cpu_clk_in <= 1'b0;
    end else begin
      cpu_div <= (cpu_div == 4'd11) ? 4'd0 : cpu_div + 4'd1;
      snes_cpu_clk_in <= (cpu_div >= 4'd6);
    end
  end

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic ready_of(input int which);
    case (which)
      0: return ctx_rdy;
      1: return mcu_rdy;
      default: return dma_rdy;
    endcase
  endfunction

  task automatic wait_ready(input int which);
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK2);
      cycles++;
    end while (!ready_of(which) && cycles < WAIT_LIMIT);
    if (!ready_of(which)) begin
      n_errors++;
      $display("timeout at %0t ns: requester %0d never raised its ready", $time, which);
    end
  endtask

  task automatic wait_dead_level(input logic level, output int cycles);
    cycles = 0;
    do begin
      @(negedge CLK2);
      cycles++;
    end while (snes_dead !== level && cycles < 4 * DEAD_TIMEOUT);
    if (snes_dead !== level) begin
      n_errors++;
      $display("timeout at %0t ns: snes_dead never went to %0b", $time, level);
    end
  endtask

  // even byte on the high lane, odd byte on the low lane
  function automatic void model_write(input logic [7:0] addr, input logic [7:0] lo_byte,
                                      input logic [7:0] hi_byte, input logic word);
    if (!addr[0]) ref_mem[{addr[7:1], 1'b0}] = hi_byte;
    if (addr[0] || word) ref_mem[{addr[7:1], 1'b1}] = lo_byte;
  endfunction

  function automatic logic [15:0] dma_expect(input logic [7:0] addr);
    logic [15:0] w;
    w = {ref_mem[{addr[7:1], 1'b0}], ref_mem[{addr[7:1], 1'b1}]};
    return addr[0] ? w : {w[7:0], w[15:8]}; // swapped on even addresses
  endfunction

  task automatic mcu_access(input logic rd, input logic [7:0] addr, input logic [7:0] data);
    @(posedge CLK2);
    mcu_addr <= {16'h0, addr};
    mcu_dout <= data;
    mcu_rrq <= rd;
    mcu_wrq <= !rd;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    wait_ready(1);
  endtask

  task automatic dma_access(input logic rd, input logic [7:0] addr, input logic [15:0] data,
                            input logic word);
    @(posedge CLK2);
    dma_addr <= {16'h0, addr};
    dma_dout <= data;
    dma_word <= word;
    dma_rrq <= rd;
    dma_wrq <= !rd;
    @(posedge CLK2);
    dma_rrq <= 1'b0;
    dma_wrq <= 1'b0;
    wait_ready(2);
  endtask

  task automatic ctx_write(input logic [7:0] addr, input logic [15:0] data, input logic word);
    model_write(addr, data[15:8], data[7:0], word);
    @(posedge CLK2);
    ctx_addr <= {16'h0, addr};
    ctx_dout <= data;
    ctx_word <= word;
    ctx_wrq <= 1'b1;
    @(posedge CLK2);
    ctx_wrq <= 1'b0;
    wait_ready(0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int unsigned seed;
    int unsigned dummy;
    int          fails;
    int          cycles;
    int          t_ctx;
    int          t_mcu;
    int          t_dma;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [15:0] d;
    logic        w;
    seed = 65;
    dummy = $urandom(seed);
    SNES_reset_strobe = 1'b1;
    snes_read_in = 1'b1; // strobes inactive high
    snes_write_in = 1'b1;
    rom_hit = 1'b0;
    mapped_addr = '0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_dout = '0;
    ctx_wrq = 1'b0;
    ctx_addr = '0;
    ctx_dout = '0;
    ctx_word = 1'b0;
    dma_rrq = 1'b0;
    dma_wrq = 1'b0;
    dma_addr = '0;
    dma_dout = '0;
    dma_word = 1'b0;
    for (int i = 0; i < 256; i++) ref_mem[i] = 8'(i * 37 + 11);
    for (int i = 0; i < 128; i++) rom_mem[i] = {ref_mem[2 * i], ref_mem[2 * i + 1]};
    repeat (3) @(posedge CLK2);
    SNES_reset_strobe <= 1'b0;
    @(negedge CLK2);
    compare_value(ctx_rdy, 1, "ctx_rdy after reset");
    compare_value(mcu_rdy, 1, "mcu_rdy after reset");
    compare_value(dma_rdy, 1, "dma_rdy after reset");
    compare_value(rom_we, 1, "rom_we after reset");
    compare_value(rom_data_oe, 0, "rom_data_oe after reset");

    // mcu bytes with the console dead
    for (int i = 0; i < N_MCU; i++) begin
      wr_addr[i] = 8'($urandom);
      d = 16'($urandom);
      model_write(wr_addr[i], d[7:0], d[7:0], 1'b0);
      mcu_access(1'b0, wr_addr[i], d[7:0]);
    end
    for (int i = 0; i < N_MCU; i++) begin
      mcu_access(1'b1, wr_addr[i], 8'h00);
      compare_value(mcu_din, ref_mem[wr_addr[i]], "mcu read after mcu write");
    end

    // dma words and bytes
    for (int i = 0; i < N_DMA; i++) begin
      wr_addr[i] = 8'($urandom);
      d = 16'($urandom);
      w = 1'($urandom);
      model_write(wr_addr[i], d[15:8], d[7:0], w);
      dma_access(1'b0, wr_addr[i], d, w);
    end
    for (int i = 0; i < N_DMA; i++) begin
      dma_access(1'b1, wr_addr[i], 16'h0000, 1'($urandom));
      compare_value(dma_din, dma_expect(wr_addr[i]), "dma read after dma write");
    end

    // ctx writes seen through mcu reads of both bytes of the word
    for (int i = 0; i < N_CTX; i++) begin
      a = 8'($urandom);
      ctx_write(a, 16'($urandom), 1'($urandom));
      mcu_access(1'b1, a, 8'h00);
      compare_value(mcu_din, ref_mem[a], "mcu read after ctx write");
      mcu_access(1'b1, a ^ 8'h01, 8'h00);
      compare_value(mcu_din, ref_mem[a ^ 8'h01], "mcu read of ctx neighbour byte");
    end

    // three requesters on one edge
    a = 8'($urandom);
    b = 8'($urandom);
    d = 16'($urandom);
    model_write(a, d[15:8], d[7:0], 1'b1);
    @(posedge CLK2);
    ctx_addr <= {16'h0, a};
    ctx_dout <= d;
    ctx_word <= 1'b1;
    ctx_wrq <= 1'b1;
    mcu_addr <= {16'h0, a};
    mcu_rrq <= 1'b1;
    dma_addr <= {16'h0, b};
    dma_word <= 1'b1;
    dma_rrq <= 1'b1;
    @(posedge CLK2);
    ctx_wrq <= 1'b0;
    mcu_rrq <= 1'b0;
    dma_rrq <= 1'b0;
    t_ctx = 0;
    t_mcu = 0;
    t_dma = 0;
    cycles = 0;
    do begin
      @(negedge CLK2);
      cycles++;
      if (ctx_rdy && t_ctx == 0) t_ctx = cycles;
      if (mcu_rdy && t_mcu == 0) t_mcu = cycles;
      if (dma_rdy && t_dma == 0) t_dma = cycles;
    end while (!(ctx_rdy && mcu_rdy && dma_rdy) && cycles < 3 * WAIT_LIMIT);
    if (!(ctx_rdy && mcu_rdy && dma_rdy)) begin
      n_errors++;
      $display("timeout at %0t ns: concurrent requests did not all finish", $time);
    end
    compare_value(t_ctx < t_mcu, 1, "ctx finishes before mcu");
    compare_value(t_mcu < t_dma, 1, "mcu finishes before dma");
    compare_value(mcu_din, ref_mem[a], "mcu read behind ctx write");
    compare_value(dma_din, dma_expect(b), "dma read behind ctx write");

    // wake the console, let it die, wake it again and read on free slots
    @(posedge CLK2);
    cpu_clk_run <= 1'b1;
    wait_dead_level(1'b0, cycles);
    @(posedge CLK2);
    cpu_clk_run <= 1'b0;
    repeat (2) @(posedge CLK2); // low level now sampled
    wait_dead_level(1'b1, cycles);
    compare_value(cycles <= DEAD_TIMEOUT + 4, 1, "snes_dead rise latency");
    @(posedge CLK2);
    cpu_clk_run <= 1'b1;
    wait_dead_level(1'b0, cycles);
    a = 8'($urandom);
    mcu_access(1'b1, a, 8'h00);
    compare_value(mcu_din, ref_mem[a], "mcu read with live console");
    @(posedge CLK2);
    cpu_clk_run <= 1'b0;

    fails = u_dut.u_arbiter.u_asserts.assert_fails;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", n_checks, n_errors, fails);
    if (n_errors == 0 && fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
verilog/snes_bus_pkg.sv
verilog/rom_bus_pkg.sv
verilog/rom_req_if.sv
verilog/snes_bus_sync.sv
verilog/rom_request_port.sv
verilog/rom_arbiter.sv
verilog/rom_datapath.sv
verilog/snes_mem_ctrl.sv
testbench/snes_mem_ctrl_asserts.sv
testbench/tb_snes_mem_ctrl.sv

//--- Bender.yml
package:
  name: snes_mem_ctrl

dependencies: {}

sources:
  # packages and interface first
  - verilog/snes_bus_pkg.sv
  - verilog/rom_bus_pkg.sv
  - verilog/rom_req_if.sv
  - verilog/snes_bus_sync.sv
  - verilog/rom_request_port.sv
  - verilog/rom_arbiter.sv
  - verilog/rom_datapath.sv
  - verilog/snes_mem_ctrl.sv
  - target: simulation
    files:
      - testbench/snes_mem_ctrl_asserts.sv
      - testbench/tb_snes_mem_ctrl.sv
